// File: rtl/riscv_isa_pkg.sv
// RV32I subset encodings, field positions and base types that the RTL and the testbench import
package riscv_isa_pkg;

	localparam int xlen = 32;

	typedef logic [4:0]      reg_addr_t;
	typedef logic [xlen-1:0] word_t;
	typedef logic [xlen-3:0] word_addr_t;

	// --------------------
	// opcodes kept by this core
	typedef enum logic [6:0] {
		op_rtype  = 7'b0110011,
		op_itype  = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111
	} opcode_t;

	// funct3 codes
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;
	localparam logic [2:0] f3_beq     = 3'b000;
	localparam logic [2:0] f3_bne     = 3'b001;

	// add is zero so an all-zero bubble decodes cleanly
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_slt = 3'd4
	} alu_op_t;

	// addi x0, x0, 0
	localparam word_t nop_instr = 32'h0000_0013;

	// --------------------
	// lsb of each instruction field
	localparam int pos_opcode = 0;
	localparam int pos_rd     = 7;
	localparam int pos_funct3 = 12;
	localparam int pos_rs1    = 15;
	localparam int pos_rs2    = 20;
	localparam int pos_sub    = 30;
	localparam int pos_sign   = 31;

	// both memory ports carry words with the byte order reversed
	function automatic word_t byte_swap(word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

endpackage

// File: rtl/pipe_pkg.sv
// pipeline stage payloads and the data port request shared by the RTL and the testbench
package pipe_pkg;
	import riscv_isa_pkg::*;

	// control bits that travel with an instruction
	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		// rd receives pc+4
		logic link;
		// operand b is the immediate
		logic alu_src;
	} ctrl_t;

	// --------------------
	typedef struct packed {
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t     ctrl;
		alu_op_t   alu_op;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     rs1_val;
		word_t     rs2_val;
		word_t     imm;
		word_t     pc_plus4;
	} id_ex_t;

	typedef struct packed {
		ctrl_t     ctrl;
		reg_addr_t rd;
		word_t     alu_result;
		word_t     store_data;
		word_t     pc_plus4;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t     ctrl;
		reg_addr_t rd;
		word_t     alu_result;
		word_t     load_data;
		word_t     pc_plus4;
	} mem_wb_t;

	// data port request, wdata already byte swapped
	typedef struct packed {
		logic       ren;
		logic       wen;
		word_addr_t addr;
		word_t      wdata;
	} dmem_req_t;

	typedef enum logic [1:0] {
		fwd_none = 2'd0,
		fwd_mem  = 2'd1,
		fwd_wb   = 2'd2
	} fwd_sel_t;

endpackage

// File: rtl/stage_reg.sv
// pipeline register between two stages, instantiated once per payload type
`timescale 1ns/100ps

module stage_reg import pipe_pkg::*; #(
	parameter type payload_t = id_ex_t
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     hold,
	input  logic     bubble,
	input  payload_t d,
	output payload_t q
);

	// hold beats bubble so a frozen pipe keeps its contents
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q <= payload_t'('0);
		end else if (!hold) begin
			q <= bubble ? payload_t'('0) : d;
		end
	end

	// the pipe comes out of reset with no live strobes
	assert property (@(posedge clk) !rst_n |=> q.ctrl == '0)
		else $error("stage register left reset with control bits set");

endmodule

// File: rtl/fetch_unit.sv
// program counter and instruction fetch feeding the fetch/decode register
`timescale 1ns/100ps

module fetch_unit import riscv_isa_pkg::*, pipe_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       freeze,
	input  logic       decode_hold,
	input  logic       redirect,
	input  word_t      target,
	output word_addr_t imem_addr,
	input  word_t      imem_rdata,
	output if_id_t     if_id
);

	word_t pc;

	// word address of the current pc
	assign imem_addr = pc[xlen-1:2];

	// --------------------
	// pc and fetch/decode register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc    <= '0;
			if_id <= '{pc: '0, instr: nop_instr};
		end else if (!freeze && !decode_hold) begin
			if (redirect) begin
				pc    <= target;
				// the word fetched behind a taken jump never reaches decode
				if_id <= '{pc: pc, instr: nop_instr};
			end else begin
				pc    <= pc + word_t'(4);
				if_id <= '{pc: pc, instr: byte_swap(imem_rdata)};
			end
		end
	end

endmodule

// File: rtl/decoder.sv
// decode stage logic with control, immediates and branch resolution
`timescale 1ns/100ps

module decoder import riscv_isa_pkg::*, pipe_pkg::*; (
	input  if_id_t  if_id,
	input  word_t   rs1_val,
	input  word_t   rs2_val,
	output ctrl_t   ctrl,
	output alu_op_t alu_op,
	output word_t   imm,
	output logic    is_branch,
	output logic    is_jal,
	output logic    is_jalr,
	output logic    taken,
	output word_t   target,
	output id_ex_t  id_ex
);

	word_t      instr;
	opcode_t    opcode;
	logic [2:0] funct3;
	reg_addr_t  rs1;
	reg_addr_t  rs2;
	reg_addr_t  rd;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;
	logic       src_equal;

	// register and immediate ops share the funct3 map, only R-type has sub
	function automatic alu_op_t arith_op(logic [2:0] f3, logic sub);
		case (f3)
			f3_add_sub: return sub ? alu_sub : alu_add;
			f3_slt:     return alu_slt;
			f3_or:      return alu_or;
			f3_and:     return alu_and;
			default:    return alu_add;
		endcase
	endfunction

	assign instr  = if_id.instr;
	assign opcode = opcode_t'(instr[pos_opcode +: 7]);
	assign funct3 = instr[pos_funct3 +: 3];
	assign rs1    = instr[pos_rs1 +: 5];
	assign rs2    = instr[pos_rs2 +: 5];
	assign rd     = instr[pos_rd +: 5];

	// --------------------
	// immediate formats
	assign imm_i = {{20{instr[pos_sign]}}, instr[31:20]};
	assign imm_s = {{20{instr[pos_sign]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[pos_sign]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[pos_sign]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		ctrl      = '0;
		alu_op    = alu_add;
		imm       = imm_i;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		is_jalr   = 1'b0;
		case (opcode)
			op_rtype: begin
				ctrl.reg_write = 1'b1;
				alu_op         = arith_op(funct3, instr[pos_sub]);
			end
			op_itype: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				alu_op         = arith_op(funct3, 1'b0);
			end
			op_load: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.alu_src   = 1'b1;
			end
			op_store: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				imm            = imm_s;
			end
			op_branch: begin
				is_branch = 1'b1;
				imm       = imm_b;
			end
			op_jal: begin
				ctrl.reg_write = 1'b1;
				ctrl.link      = 1'b1;
				is_jal         = 1'b1;
				imm            = imm_j;
			end
			op_jalr: begin
				ctrl.reg_write = 1'b1;
				ctrl.link      = 1'b1;
				is_jalr        = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// --------------------
	// branch compare and target
	assign src_equal = (rs1_val == rs2_val);
	assign taken     = is_branch && ((funct3 == f3_beq && src_equal) ||
	                                 (funct3 == f3_bne && !src_equal));
	// jalr clears bit 0 of its target
	assign target    = is_jalr ? ((rs1_val + imm) & ~word_t'(1)) : (if_id.pc + imm);

	assign id_ex = '{ctrl: ctrl, alu_op: alu_op, rs1: rs1, rs2: rs2, rd: rd,
	                 rs1_val: rs1_val, rs2_val: rs2_val, imm: imm,
	                 pc_plus4: if_id.pc + word_t'(4)};

	always_comb begin
		assert final ($onehot0({is_branch, is_jal, is_jalr}))
			else $error("more than one control transfer kind decoded");
	end

endmodule

// File: rtl/reg_file.sv
// 32-entry integer register file with x0 tied to zero
`timescale 1ns/100ps

module reg_file import riscv_isa_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      we,
	input  reg_addr_t waddr,
	input  word_t     wdata,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	output word_t     rdata1,
	output word_t     rdata2
);

	word_t regs [32];

	// a read of the register being written sees the new value
	function automatic word_t read_port(reg_addr_t raddr);
		if (raddr == '0) begin
			return '0;
		end
		return (we && waddr == raddr) ? wdata : regs[raddr];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

endmodule

// File: rtl/hazard_unit.sv
// interlocks, fetch redirect and operand forward selects for the pipeline
`timescale 1ns/100ps

module hazard_unit import riscv_isa_pkg::*, pipe_pkg::*; (
	input  if_id_t   if_id,
	input  logic     is_branch,
	input  logic     is_jalr,
	input  logic     taken,
	input  logic     is_jal,
	input  id_ex_t   id_ex_q,
	input  ex_mem_t  ex_mem_q,
	input  mem_wb_t  mem_wb_q,
	output logic     decode_hold,
	output logic     redirect,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b
);

	opcode_t   opcode;
	reg_addr_t rs1;
	reg_addr_t rs2;
	logic      uses_rs1;
	logic      uses_rs2;
	logic      load_use;
	logic      branch_dep;

	// true when the decoding instruction reads register rd
	function automatic logic reads(reg_addr_t rd);
		return rd != '0 && ((uses_rs1 && rs1 == rd) || (uses_rs2 && rs2 == rd));
	endfunction

	// memory stage wins over writeback, x0 never forwards
	function automatic fwd_sel_t select(reg_addr_t src);
		if (ex_mem_q.ctrl.reg_write && ex_mem_q.rd != '0 && ex_mem_q.rd == src) begin
			return fwd_mem;
		end
		if (mem_wb_q.ctrl.reg_write && mem_wb_q.rd != '0 && mem_wb_q.rd == src) begin
			return fwd_wb;
		end
		return fwd_none;
	endfunction

	assign opcode   = opcode_t'(if_id.instr[pos_opcode +: 7]);
	assign rs1      = if_id.instr[pos_rs1 +: 5];
	assign rs2      = if_id.instr[pos_rs2 +: 5];
	assign uses_rs1 = (opcode != op_jal);
	assign uses_rs2 = (opcode == op_rtype) || (opcode == op_store) || (opcode == op_branch);

	// --------------------
	// stalls
	always_comb begin
		load_use   = id_ex_q.ctrl.mem_read && reads(id_ex_q.rd);
		// compares and jalr read the register file, so producers must reach writeback
		branch_dep = (is_branch || is_jalr) &&
		             ((id_ex_q.ctrl.reg_write && reads(id_ex_q.rd)) ||
		              (ex_mem_q.ctrl.reg_write && reads(ex_mem_q.rd)));
		fwd_a      = select(id_ex_q.rs1);
		fwd_b      = select(id_ex_q.rs2);
	end

	assign decode_hold = load_use || branch_dep;
	assign redirect    = (is_jal || is_jalr || taken) && !decode_hold;

	always_comb begin
		assert final (!(redirect && decode_hold))
			else $error("fetch redirected while decode is held");
	end

endmodule

// File: rtl/execute_unit.sv
// execute stage with operand forwarding and the ALU
`timescale 1ns/100ps

module execute_unit import riscv_isa_pkg::*, pipe_pkg::*; (
	input  id_ex_t   id_ex_q,
	input  fwd_sel_t fwd_a,
	input  fwd_sel_t fwd_b,
	input  word_t    mem_val,
	input  word_t    wb_val,
	output ex_mem_t  ex_mem
);

	word_t op_a;
	word_t rs2_fwd;
	word_t op_b;
	word_t result;

	function automatic word_t forward(fwd_sel_t sel, word_t reg_val,
	                                  word_t from_mem, word_t from_wb);
		case (sel)
			fwd_mem: return from_mem;
			fwd_wb:  return from_wb;
			default: return reg_val;
		endcase
	endfunction

	// --------------------
	// operands
	assign op_a    = forward(fwd_a, id_ex_q.rs1_val, mem_val, wb_val);
	assign rs2_fwd = forward(fwd_b, id_ex_q.rs2_val, mem_val, wb_val);
	assign op_b    = id_ex_q.ctrl.alu_src ? id_ex_q.imm : rs2_fwd;

	always_comb begin
		case (id_ex_q.alu_op)
			alu_add: result = op_a + op_b;
			alu_sub: result = op_a - op_b;
			alu_and: result = op_a & op_b;
			alu_or:  result = op_a | op_b;
			// signed compare
			alu_slt: result = word_t'($signed(op_a) < $signed(op_b));
			default: result = op_a + op_b;
		endcase
	end

	// forwarded rs2 is the store data
	assign ex_mem = '{ctrl: id_ex_q.ctrl, rd: id_ex_q.rd, alu_result: result,
	                  store_data: rs2_fwd, pc_plus4: id_ex_q.pc_plus4};

endmodule

// File: rtl/riscv_pipeline.sv
// five-stage RV32I subset core with an instruction port and a data port
`timescale 1ns/100ps

module riscv_pipeline import riscv_isa_pkg::*, pipe_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	output word_addr_t imem_addr,
	input  word_t      imem_rdata,
	input  logic       imem_stall,
	output dmem_req_t  dmem_req,
	input  word_t      dmem_rdata,
	input  logic       dmem_stall
);

	logic     freeze;
	logic     decode_hold;
	logic     redirect;
	word_t    branch_target;
	if_id_t   if_id;
	word_t    rs1_val;
	word_t    rs2_val;
	logic     is_branch;
	logic     is_jal;
	logic     is_jalr;
	logic     taken;
	id_ex_t   id_ex_d;
	id_ex_t   id_ex_q;
	ex_mem_t  ex_mem_d;
	ex_mem_t  ex_mem_q;
	mem_wb_t  mem_wb_d;
	mem_wb_t  mem_wb_q;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	word_t    mem_val;
	word_t    wb_val;

	// either port stalling freezes every stage
	assign freeze = imem_stall || dmem_stall;

	// --------------------
	// fetch and decode
	fetch_unit u_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.freeze      (freeze),
		.decode_hold (decode_hold),
		.redirect    (redirect),
		.target      (branch_target),
		.imem_addr   (imem_addr),
		.imem_rdata  (imem_rdata),
		.if_id       (if_id)
	);

	reg_file u_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.we     (mem_wb_q.ctrl.reg_write),
		.waddr  (mem_wb_q.rd),
		.wdata  (wb_val),
		.raddr1 (if_id.instr[pos_rs1 +: 5]),
		.raddr2 (if_id.instr[pos_rs2 +: 5]),
		.rdata1 (rs1_val),
		.rdata2 (rs2_val)
	);

	decoder u_dec (
		.if_id     (if_id),
		.rs1_val   (rs1_val),
		.rs2_val   (rs2_val),
		.ctrl      (),
		.alu_op    (),
		.imm       (),
		.is_branch (is_branch),
		.is_jal    (is_jal),
		.is_jalr   (is_jalr),
		.taken     (taken),
		.target    (branch_target),
		.id_ex     (id_ex_d)
	);

	hazard_unit u_hazard (
		.if_id       (if_id),
		.is_branch   (is_branch),
		.is_jalr     (is_jalr),
		.taken       (taken),
		.is_jal      (is_jal),
		.id_ex_q     (id_ex_q),
		.ex_mem_q    (ex_mem_q),
		.mem_wb_q    (mem_wb_q),
		.decode_hold (decode_hold),
		.redirect    (redirect),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b)
	);

	stage_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk    (clk),
		.rst_n  (rst_n),
		.hold   (freeze),
		.bubble (decode_hold),
		.d      (id_ex_d),
		.q      (id_ex_q)
	);

	// --------------------
	// execute and memory
	assign mem_val = ex_mem_q.ctrl.link ? ex_mem_q.pc_plus4 : ex_mem_q.alu_result;

	execute_unit u_ex (
		.id_ex_q (id_ex_q),
		.fwd_a   (fwd_a),
		.fwd_b   (fwd_b),
		.mem_val (mem_val),
		.wb_val  (wb_val),
		.ex_mem  (ex_mem_d)
	);

	stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk    (clk),
		.rst_n  (rst_n),
		.hold   (freeze),
		.bubble (1'b0),
		.d      (ex_mem_d),
		.q      (ex_mem_q)
	);

	assign dmem_req = '{ren: ex_mem_q.ctrl.mem_read, wen: ex_mem_q.ctrl.mem_write,
	                    addr: ex_mem_q.alu_result[xlen-1:2],
	                    wdata: byte_swap(ex_mem_q.store_data)};

	assign mem_wb_d = '{ctrl: ex_mem_q.ctrl, rd: ex_mem_q.rd,
	                    alu_result: ex_mem_q.alu_result,
	                    load_data: byte_swap(dmem_rdata), pc_plus4: ex_mem_q.pc_plus4};

	stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk    (clk),
		.rst_n  (rst_n),
		.hold   (freeze),
		.bubble (1'b0),
		.d      (mem_wb_d),
		.q      (mem_wb_q)
	);

	// writeback select
	assign wb_val = mem_wb_q.ctrl.link ? mem_wb_q.pc_plus4 :
	                mem_wb_q.ctrl.mem_read ? mem_wb_q.load_data : mem_wb_q.alu_result;

endmodule

// File: tb/tb_clock.sv
// testbench clock and reset source, 40 ns period, reset held low for 4 cycles
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
	end

	always #20 clk = ~clk;

	// reset stays low until release_reset is called
	task automatic assert_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
	endtask

	task automatic release_reset();
		rst_n = 1'b1;
	endtask

endmodule

// File: tb/tb_checker.sv
// store monitor instanced by the testbench top that compares data port stores with an instruction-set model
`timescale 1ns/100ps

module tb_checker import riscv_isa_pkg::*, pipe_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input dmem_req_t dmem_req,
	input logic      imem_stall,
	input logic      dmem_stall,
	input word_t     prog [256],
	input word_t     data_img [256]
);

	word_t exp_addr [$];
	word_t exp_data [$];
	int    got;
	int    errors;
	int    failures;
	int    tests_run;
	logic  active;
	logic  held;
	string test_name;

	initial begin
		got       = 0;
		errors    = 0;
		failures  = 0;
		tests_run = 0;
		active    = 1'b0;
	end

	function automatic word_t unswap(word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic word_t ref_alu(logic [2:0] f3, logic sub, word_t a, word_t b);
		case (f3)
			3'b000:  return sub ? a - b : a + b;
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b110:  return a | b;
			3'b111:  return a & b;
			default: return a + b;
		endcase
	endfunction

	// --------------------
	// instruction-set model that runs until the jal-to-self at the end
	function automatic void interpret();
		word_t      regs [32];
		word_t      mem [256];
		word_t      pc;
		word_t      next;
		word_t      ins;
		word_t      a;
		word_t      b;
		word_t      imm_i;
		word_t      imm_s;
		word_t      imm_b;
		word_t      imm_j;
		word_t      res;
		word_t      ea;
		logic       wr;
		logic [2:0] f3;
		reg_addr_t  rd;
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			mem[i] = data_img[i];
		end
		pc = '0;
		for (int step = 0; step < 4000; step++) begin
			ins   = prog[pc[9:2]];
			if (ins[6:0] == 7'b1101111 && ins[31:12] == 20'd0) begin
				break;
			end
			f3    = ins[14:12];
			rd    = ins[11:7];
			a     = regs[ins[19:15]];
			b     = regs[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			next  = pc + 32'd4;
			res   = '0;
			wr    = 1'b0;
			case (opcode_t'(ins[6:0]))
				op_rtype: begin
					res = ref_alu(f3, ins[30], a, b);
					wr  = 1'b1;
				end
				op_itype: begin
					res = ref_alu(f3, 1'b0, a, imm_i);
					wr  = 1'b1;
				end
				op_load: begin
					ea  = a + imm_i;
					res = mem[ea[9:2]];
					wr  = 1'b1;
				end
				op_store: begin
					ea           = a + imm_s;
					mem[ea[9:2]] = b;
					exp_addr.push_back(ea >> 2);
					exp_data.push_back(b);
				end
				op_branch: begin
					if ((f3 == f3_beq) ? (a == b) : (a != b)) begin
						next = pc + imm_b;
					end
				end
				op_jal: begin
					res  = pc + 32'd4;
					next = pc + imm_j;
					wr   = 1'b1;
				end
				op_jalr: begin
					res  = pc + 32'd4;
					next = (a + imm_i) & ~32'd1;
					wr   = 1'b1;
				end
				default: begin
				end
			endcase
			if (wr && rd != '0) begin
				regs[rd] = res;
			end
			pc = next;
		end
	endfunction

	task automatic begin_test(string name);
		test_name = name;
		interpret();
		got    = 0;
		active = 1'b1;
	endtask

	// --------------------
	// store compare
	always @(posedge clk) begin
		if (!rst_n) begin
			if (dmem_req.wen || dmem_req.ren) begin
				$display("memory strobe seen while reset is asserted");
				errors++;
			end
			held <= 1'b0;
		end else begin
			if (active && dmem_req.wen && !dmem_stall && !held) begin
				if (got >= exp_addr.size()) begin
					$display("unexpected extra store to word address %h", dmem_req.addr);
					errors++;
				end else begin
					if (dmem_req.addr != exp_addr[got][29:0]) begin
						$display("CHECK FAILED dmem_req.addr store %0d expected %h got %h",
						         got, exp_addr[got][29:0], dmem_req.addr);
						errors++;
					end
					if (unswap(dmem_req.wdata) != exp_data[got]) begin
						$display("CHECK FAILED dmem_req.wdata store %0d expected %h got %h",
						         got, exp_data[got], unswap(dmem_req.wdata));
						errors++;
					end
				end
				got++;
			end
			// a frozen pipe presents its completed store again
			held <= dmem_req.wen && (held || !dmem_stall) && (imem_stall || dmem_stall);
		end
	end

	task automatic end_test();
		int cycles;
		int start_errors;
		start_errors = errors;
		cycles       = 0;
		while (got < exp_addr.size() && cycles < 3000) begin
			@(posedge clk);
			cycles++;
		end
		if (got < exp_addr.size()) begin
			$display("test %s timed out with %0d of %0d stores seen",
			         test_name, got, exp_addr.size());
			errors++;
		end
		// watch for stores beyond the expected list
		cycles = 0;
		while (cycles < 40) begin
			@(posedge clk);
			cycles++;
		end
		active = 1'b0;
		tests_run++;
		if (errors != start_errors) begin
			failures++;
		end
		$display("test %s: %s, %0d stores", test_name,
		         (errors != start_errors) ? "FAILED" : "passed", got);
	endtask

	task automatic report_counts();
		$display("tests run %0d, tests failed %0d, check errors %0d",
		         tests_run, failures, errors);
	endtask

endmodule

// File: tb/tb_top.sv
// top module of the simulation holding the memory models, test programs and stall stimulus
`timescale 1ns/100ps

module tb_top import riscv_isa_pkg::*, pipe_pkg::*;;

	localparam word_t seed = 32'he9f8_805e;

	logic       clk;
	logic       rst_n;
	word_addr_t imem_addr;
	word_t      imem_rdata;
	logic       imem_stall;
	dmem_req_t  dmem_req;
	word_t      dmem_rdata;
	logic       dmem_stall;
	word_t      imem [256];
	word_t      dmem [256];
	word_t      prog [256];
	word_t      data_img [256];
	word_t      rng;
	word_t      stall_rng;
	logic       stall_en;
	int         n_instr;

	tb_clock clk_gen (.clk(clk), .rst_n(rst_n));

	riscv_pipeline UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.imem_stall (imem_stall),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata),
		.dmem_stall (dmem_stall)
	);

	tb_checker chk (
		.clk        (clk),
		.rst_n      (rst_n),
		.dmem_req   (dmem_req),
		.imem_stall (imem_stall),
		.dmem_stall (dmem_stall),
		.prog       (prog),
		.data_img   (data_img)
	);

	function automatic word_t xorshift(word_t s);
		word_t x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t swap_bytes(word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// --------------------
	// memory models hold byte-swapped words
	assign imem_rdata = imem[imem_addr[7:0]];
	// load data only while a read is presented
	assign dmem_rdata = dmem_req.ren ? dmem[dmem_req.addr[7:0]] : '0;

	always @(posedge clk) begin
		if (rst_n && dmem_req.wen && !dmem_stall) begin
			dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
		end
	end

	// random stall pulses on about one cycle in four per port
	always @(negedge clk) begin
		if (stall_en) begin
			stall_rng  = xorshift(stall_rng);
			imem_stall = (stall_rng[1:0] == 2'd0);
			dmem_stall = (stall_rng[5:4] == 2'd0);
		end else begin
			imem_stall = 1'b0;
			dmem_stall = 1'b0;
		end
	end

	// --------------------
	// instruction encoders
	function automatic word_t enc_r(logic sub, reg_addr_t rs2, reg_addr_t rs1,
	                                logic [2:0] f3, reg_addr_t rd);
		return {1'b0, sub, 5'd0, rs2, rs1, f3, rd, op_rtype};
	endfunction

	function automatic word_t enc_i(opcode_t op, logic [11:0] imm, reg_addr_t rs1,
	                                logic [2:0] f3, reg_addr_t rd);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
	endfunction

	function automatic word_t enc_b(logic [2:0] f3, logic [12:0] imm, reg_addr_t rs1,
	                                reg_addr_t rs2);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	task automatic emit(word_t w);
		prog[n_instr] = w;
		n_instr++;
	endtask

	task automatic clear_image();
		n_instr = 0;
		rng     = seed;
		for (int i = 0; i < 256; i++) begin
			prog[i]     = nop_instr;
			rng         = xorshift(rng);
			data_img[i] = rng;
		end
	endtask

	// --------------------
	// programs
	task automatic build_arith();
		word_t     r;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		int        k;
		clear_image();
		for (int i = 1; i < 7; i++) begin
			emit(enc_i(op_load, 12'(512 + 4 * i), 5'd0, 3'b010, reg_addr_t'(i)));
		end
		// every operation kind comes up in turn, operands are random
		for (int n = 0; n < 24; n++) begin
			rng = xorshift(rng);
			r   = rng;
			k   = n % 9;
			rd  = reg_addr_t'(1 + r[10:8] % 3'd7);
			rs1 = (n % 2 == 0) ? rd : reg_addr_t'(1 + r[13:11] % 3'd7);
			rs2 = reg_addr_t'(1 + r[16:14] % 3'd7);
			case (k)
				0: emit(enc_r(1'b0, rs2, rs1, f3_add_sub, rd));
				1: emit(enc_r(1'b1, rs2, rs1, f3_add_sub, rd));
				2: emit(enc_r(1'b0, rs2, rs1, f3_and, rd));
				3: emit(enc_r(1'b0, rs2, rs1, f3_or, rd));
				4: emit(enc_r(1'b0, rs2, rs1, f3_slt, rd));
				5: emit(enc_i(op_itype, r[31:20], rs1, f3_add_sub, rd));
				6: emit(enc_i(op_itype, r[31:20], rs1, f3_and, rd));
				7: emit(enc_i(op_itype, r[31:20], rs1, f3_or, rd));
				default: emit(enc_i(op_itype, r[31:20], rs1, f3_slt, rd));
			endcase
			emit(enc_s(12'(768 + 4 * n), rd, 5'd0));
		end
		emit(enc_j(21'd0, 5'd0));
	endtask

	task automatic build_load_use();
		clear_image();
		emit(enc_i(op_load, 12'd512, 5'd0, 3'b010, 5'd1));
		emit(enc_i(op_itype, 12'd7, 5'd1, f3_add_sub, 5'd2));
		emit(enc_s(12'd768, 5'd2, 5'd0));
		emit(enc_i(op_load, 12'd516, 5'd0, 3'b010, 5'd3));
		emit(enc_r(1'b0, 5'd1, 5'd3, f3_add_sub, 5'd4));
		emit(enc_s(12'd772, 5'd4, 5'd0));
		emit(enc_j(21'd0, 5'd0));
	endtask

	task automatic build_branches();
		clear_image();
		emit(enc_i(op_itype, 12'd5, 5'd0, f3_add_sub, 5'd1));
		emit(enc_i(op_itype, 12'd5, 5'd0, f3_add_sub, 5'd2));
		emit(enc_b(f3_beq, 13'd8, 5'd1, 5'd2));
		emit(enc_s(12'd800, 5'd1, 5'd0));
		emit(enc_s(12'd768, 5'd2, 5'd0));
		emit(enc_b(f3_bne, 13'd8, 5'd1, 5'd2));
		emit(enc_s(12'd772, 5'd1, 5'd0));
		// the next compare depends on the addi just before it
		emit(enc_i(op_itype, 12'd1, 5'd1, f3_add_sub, 5'd3));
		emit(enc_b(f3_bne, 13'd8, 5'd3, 5'd2));
		emit(enc_s(12'd804, 5'd3, 5'd0));
		emit(enc_b(f3_beq, 13'd8, 5'd3, 5'd2));
		emit(enc_s(12'd776, 5'd3, 5'd0));
		emit(enc_j(21'd0, 5'd0));
	endtask

	task automatic build_jumps();
		clear_image();
		emit(enc_j(21'd8, 5'd1));
		emit(enc_s(12'd800, 5'd1, 5'd0));
		emit(enc_s(12'd768, 5'd1, 5'd0));
		emit(enc_i(op_itype, 12'd28, 5'd0, f3_add_sub, 5'd5));
		emit(enc_i(op_jalr, 12'd0, 5'd5, 3'b000, 5'd2));
		emit(enc_s(12'd804, 5'd2, 5'd0));
		emit(enc_s(12'd808, 5'd2, 5'd0));
		emit(enc_s(12'd772, 5'd2, 5'd0));
		emit(enc_j(21'd0, 5'd0));
	endtask

	task automatic build_x0();
		clear_image();
		emit(enc_i(op_itype, 12'd123, 5'd0, f3_add_sub, 5'd0));
		emit(enc_i(op_load, 12'd512, 5'd0, 3'b010, 5'd1));
		emit(enc_r(1'b0, 5'd1, 5'd1, f3_add_sub, 5'd0));
		emit(enc_i(op_load, 12'd516, 5'd0, 3'b010, 5'd0));
		emit(enc_s(12'd768, 5'd0, 5'd0));
		emit(enc_i(op_itype, 12'd9, 5'd0, f3_add_sub, 5'd2));
		emit(enc_s(12'd772, 5'd2, 5'd0));
		emit(enc_j(21'd0, 5'd0));
	endtask

	// memories are loaded while the DUT sits in reset
	task automatic run_program(string name, logic stalls);
		for (int i = 0; i < 256; i++) begin
			imem[i] = swap_bytes(prog[i]);
			dmem[i] = swap_bytes(data_img[i]);
		end
		chk.begin_test(name);
		stall_en = stalls;
		clk_gen.release_reset();
		chk.end_test();
		stall_en = 1'b0;
		clk_gen.assert_reset();
	endtask

	initial begin
		imem_stall = 1'b0;
		dmem_stall = 1'b0;
		stall_en   = 1'b0;
		stall_rng  = xorshift(seed ^ 32'h5a5a_5a5a);
		clk_gen.assert_reset();
		build_arith();
		run_program("arith_chain", 1'b0);
		build_load_use();
		run_program("load_use", 1'b0);
		build_branches();
		run_program("branches", 1'b0);
		build_jumps();
		run_program("jumps", 1'b0);
		build_arith();
		run_program("arith_stalls", 1'b1);
		build_x0();
		run_program("reset_x0", 1'b0);
		chk.report_counts();
		if (chk.failures == 0 && chk.errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: sources.f
rtl/riscv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_reg.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/execute_unit.sv
rtl/riscv_pipeline.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_top -f sources.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
	exit 1
fi
grep -q "Test completed successfully" sim.log
